// ==== common/link_pkg.sv ====
`default_nettype none

package link_pkg;

    // Serial link timing
    localparam int CLK_FREQ     = 50_000_000;   // sys_clk in Hz
    localparam int BIT_RATE     = 3_125_000;    // Host UART baud rate
    localparam int CLKS_PER_BIT = CLK_FREQ / BIT_RATE;

    localparam int BYTE_W = 8;  // UART payload width

    // Host command opcodes in plain ASCII
    localparam logic [BYTE_W-1:0] CMD_WRITE = 8'h57;  // 'W'
    localparam logic [BYTE_W-1:0] CMD_READ  = 8'h52;  // 'R'
    localparam logic [BYTE_W-1:0] CMD_HOLD  = 8'h48;  // 'H'
    localparam logic [BYTE_W-1:0] CMD_GO    = 8'h47;  // 'G'

    // Replies back to the host
    localparam logic [BYTE_W-1:0] RSP_OK  = 8'h4b;    // 'K'
    localparam logic [BYTE_W-1:0] RSP_ERR = 8'h45;    // 'E'

endpackage

`default_nettype wire

// ==== common/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // Wishbone-style core bus
    localparam int ADDR_W = 32;  // Byte address
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Word memory shared by host and core
    localparam int MEM_WORDS  = 1024;
    localparam int WORD_IDX_W = $clog2(MEM_WORDS);
    localparam int IDX_LSB    = 2;  // Word index starts above the byte offset

endpackage

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                        sys_clk,
    input  logic                        rst_n_i,
    input  logic                        rx_i,
    output logic [link_pkg::BYTE_W-1:0] byte_o,
    output logic                        byte_req_o,
    input  logic                        byte_ack_i
);
    import link_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_t;
    typedef logic [$clog2(BYTE_W)-1:0]       bit_idx_t;

    rx_state_t         state_q;
    logic              rx_meta_q;
    logic              rx_sync_q;
    clk_cnt_t          clk_cnt_q;
    bit_idx_t          bit_idx_q;
    logic [BYTE_W-1:0] shift_q;
    logic              bit_end;
    logic              load;

    assign bit_end = clk_cnt_q == clk_cnt_t'(CLKS_PER_BIT - 1);
    // Good stop bit and the previous handshake fully closed
    assign load    = state_q == RX_STOP && bit_end && rx_sync_q && !byte_req_o && !byte_ack_i;

    // Two flop synchronizer that idles high
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at its midpoint
                    if (clk_cnt_q == clk_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt_q <= '0;
                        bit_idx_q <= '0;
                        state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == bit_idx_t'(BYTE_W - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= RX_IDLE;  // Framing error just drops the byte
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rx_sync_q, shift_q[BYTE_W-1:1]};  // LSB first
        end
        if (load) begin
            byte_o <= shift_q;
        end
    end

    // Four-phase output side where overrun bytes are lost
    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            byte_req_o <= 1'b0;
        end else if (load) begin
            byte_req_o <= 1'b1;
        end else if (byte_req_o && byte_ack_i) begin
            byte_req_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                        sys_clk,
    input  logic                        rst_n_i,
    input  logic [link_pkg::BYTE_W-1:0] byte_i,
    input  logic                        byte_req_i,
    output logic                        byte_ack_o,
    output logic                        tx_o
);
    import link_pkg::*;

    typedef logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_t;
    typedef logic [$clog2(BYTE_W + 2)-1:0]   frame_cnt_t;

    logic            busy_q;
    clk_cnt_t        clk_cnt_q;
    frame_cnt_t      bits_left_q;  // Bits still to follow the one on the line
    logic [BYTE_W:0] shift_q;      // Data bits then the stop bit
    logic            bit_end;
    logic            load;

    assign bit_end = clk_cnt_q == clk_cnt_t'(CLKS_PER_BIT - 1);
    assign load    = !busy_q && byte_req_i && !byte_ack_o;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            clk_cnt_q   <= '0;
            bits_left_q <= '0;
            tx_o        <= 1'b1;
            byte_ack_o  <= 1'b0;
        end else if (load) begin
            busy_q      <= 1'b1;
            clk_cnt_q   <= '0;
            bits_left_q <= frame_cnt_t'(BYTE_W + 1);
            tx_o        <= 1'b0;  // Start bit
            byte_ack_o  <= 1'b1;
        end else begin
            if (byte_ack_o && !byte_req_i) begin
                byte_ack_o <= 1'b0;
            end
            if (busy_q) begin
                clk_cnt_q <= clk_cnt_q + 1'b1;
                if (bit_end) begin
                    clk_cnt_q <= '0;
                    if (bits_left_q == '0) begin
                        busy_q <= 1'b0;  // End of stop bit
                        tx_o   <= 1'b1;
                    end else begin
                        tx_o        <= shift_q[0];
                        bits_left_q <= bits_left_q - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (load) begin
            shift_q <= {1'b1, byte_i};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[BYTE_W:1]};
        end
    end

endmodule

`default_nettype wire

// ==== design/command_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_engine (
    input  logic                          sys_clk,
    input  logic                          rst_n_i,
    input  logic [link_pkg::BYTE_W-1:0]   rx_byte_i,
    input  logic                          rx_req_i,
    output logic                          rx_ack_o,
    output logic [link_pkg::BYTE_W-1:0]   tx_byte_o,
    output logic                          tx_req_o,
    input  logic                          tx_ack_i,
    output logic                          mem_en_o,
    output logic                          mem_we_o,
    output logic [bus_pkg::WORD_IDX_W-1:0] mem_idx_o,
    output logic [bus_pkg::DATA_W-1:0]     mem_wdata_o,
    input  logic [bus_pkg::DATA_W-1:0]     mem_rdata_i,
    output logic                          rst_core_o
);
    import link_pkg::*;
    import bus_pkg::*;

    typedef enum logic [2:0] {
        S_OPCODE,
        S_ADDR,
        S_DATA,
        S_WRITE,
        S_READ,
        S_RDATA,
        S_SEND,
        S_SEND_END
    } state_t;

    state_t            state_q;
    logic [1:0]        byte_cnt_q;   // Address or data byte position
    logic [1:0]        reply_cnt_q;  // Reply bytes left after the current one
    logic              is_write_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] data_q;
    logic [DATA_W-1:0] rdata_q;
    logic              rx_take;

    // Bytes are taken only while collecting a command
    assign rx_take = rx_req_i && !rx_ack_o && (state_q inside {S_OPCODE, S_ADDR, S_DATA});

    assign mem_en_o    = state_q == S_WRITE || state_q == S_READ;
    assign mem_we_o    = state_q == S_WRITE;
    assign mem_idx_o   = addr_q[IDX_LSB +: WORD_IDX_W];
    assign mem_wdata_o = data_q;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= S_OPCODE;
            byte_cnt_q  <= '0;
            reply_cnt_q <= '0;
            is_write_q  <= 1'b0;
            rx_ack_o    <= 1'b0;
            tx_req_o    <= 1'b0;
            rst_core_o  <= 1'b1;  // Core held until the host says go
        end else begin
            if (rx_take) begin
                rx_ack_o <= 1'b1;
            end else if (rx_ack_o && !rx_req_i) begin
                rx_ack_o <= 1'b0;
            end
            case (state_q)
                S_OPCODE: begin
                    if (rx_take) begin
                        byte_cnt_q  <= '0;
                        reply_cnt_q <= '0;
                        is_write_q  <= rx_byte_i == CMD_WRITE;
                        state_q     <= S_SEND;
                        if (rx_byte_i == CMD_WRITE || rx_byte_i == CMD_READ) begin
                            state_q <= S_ADDR;
                        end
                        if (rx_byte_i == CMD_HOLD) begin
                            rst_core_o <= 1'b1;
                        end
                        if (rx_byte_i == CMD_GO) begin
                            rst_core_o <= 1'b0;
                        end
                    end
                end
                S_ADDR: begin
                    if (rx_take) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;  // Wraps back to zero for the data
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= is_write_q ? S_DATA : S_READ;
                        end
                    end
                end
                S_DATA: begin
                    if (rx_take) begin
                        byte_cnt_q <= byte_cnt_q + 1'b1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= S_WRITE;
                        end
                    end
                end
                S_WRITE: state_q <= S_SEND;
                S_READ:  state_q <= S_RDATA;
                S_RDATA: begin
                    reply_cnt_q <= 2'd3;
                    state_q     <= S_SEND;
                end
                S_SEND: begin
                    if (!tx_req_o && !tx_ack_i) begin
                        tx_req_o <= 1'b1;
                    end else if (tx_req_o && tx_ack_i) begin
                        tx_req_o <= 1'b0;
                        state_q  <= S_SEND_END;
                    end
                end
                default: begin
                    // Wait for the transmitter to close the handshake
                    if (!tx_ack_i) begin
                        reply_cnt_q <= reply_cnt_q - 1'b1;
                        state_q     <= (reply_cnt_q == '0) ? S_OPCODE : S_SEND;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state_q == S_OPCODE && rx_take) begin
            tx_byte_o <= (rx_byte_i == CMD_HOLD || rx_byte_i == CMD_GO) ? RSP_OK : RSP_ERR;
        end
        if (state_q == S_ADDR && rx_take) begin
            addr_q <= {addr_q[ADDR_W-BYTE_W-1:0], rx_byte_i};  // MSB first
        end
        if (state_q == S_DATA && rx_take) begin
            data_q <= {data_q[DATA_W-BYTE_W-1:0], rx_byte_i};
        end
        if (state_q == S_WRITE) begin
            tx_byte_o <= RSP_OK;
        end
        if (state_q == S_RDATA) begin
            tx_byte_o <= mem_rdata_i[DATA_W-1 -: BYTE_W];
            rdata_q   <= mem_rdata_i << BYTE_W;
        end
        if (state_q == S_SEND_END && !tx_ack_i && reply_cnt_q != '0) begin
            tx_byte_o <= rdata_q[DATA_W-1 -: BYTE_W];
            rdata_q   <= rdata_q << BYTE_W;
        end
    end

endmodule

`default_nettype wire

// ==== design/core_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_memory (
    input  logic                           sys_clk,
    input  logic                           rst_n_i,
    input  logic                           host_en_i,
    input  logic                           host_we_i,
    input  logic [bus_pkg::WORD_IDX_W-1:0] host_idx_i,
    input  logic [bus_pkg::DATA_W-1:0]     host_wdata_i,
    output logic [bus_pkg::DATA_W-1:0]     host_rdata_o,
    input  logic                           core_cyc_i,
    input  logic                           core_stb_i,
    input  logic                           core_we_i,
    input  logic [bus_pkg::STRB_W-1:0]     core_wstrb_i,
    input  logic [bus_pkg::ADDR_W-1:0]     core_addr_i,
    input  logic [bus_pkg::DATA_W-1:0]     core_data_i,
    output logic [bus_pkg::DATA_W-1:0]     core_data_o,
    output logic                           core_ack_o
);
    import bus_pkg::*;

    logic [DATA_W-1:0]     mem_q [MEM_WORDS];
    logic [WORD_IDX_W-1:0] core_idx;
    logic                  core_req;
    logic                  host_wr;
    logic                  core_wr;

    assign core_idx = core_addr_i[IDX_LSB +: WORD_IDX_W];  // High address bits ignored
    assign core_req = core_cyc_i && core_stb_i && !core_ack_o;
    assign host_wr  = host_en_i && host_we_i;
    // Host keeps the word when both sides write it at once
    assign core_wr  = core_req && core_we_i && !(host_wr && host_idx_i == core_idx);

    always_ff @(posedge sys_clk) begin
        if (host_wr) begin
            mem_q[host_idx_i] <= host_wdata_i;
        end
        if (core_wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (core_wstrb_i[b]) begin
                    mem_q[core_idx][b*8 +: 8] <= core_data_i[b*8 +: 8];
                end
            end
        end
    end

    // One registered read per side
    always_ff @(posedge sys_clk) begin
        if (host_en_i) begin
            host_rdata_o <= mem_q[host_idx_i];
        end
        if (core_req) begin
            core_data_o <= mem_q[core_idx];
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            core_ack_o <= 1'b0;
        end else begin
            core_ack_o <= core_req;  // Single cycle pulse
        end
    end

endmodule

`default_nettype wire

// ==== design/processorci_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module processorci_controller (
    input  logic                       sys_clk,
    input  logic                       rst_n_i,
    input  logic                       rx_i,
    output logic                       tx_o,
    output logic                       rst_core_o,
    input  logic                       core_cyc_i,
    input  logic                       core_stb_i,
    input  logic                       core_we_i,
    input  logic [bus_pkg::STRB_W-1:0] core_wstrb_i,
    input  logic [bus_pkg::ADDR_W-1:0] core_addr_i,
    input  logic [bus_pkg::DATA_W-1:0] core_data_i,
    output logic [bus_pkg::DATA_W-1:0] core_data_o,
    output logic                       core_ack_o
);
    import link_pkg::*;
    import bus_pkg::*;

    // Byte channels
    logic              rx_req;
    logic              rx_ack;
    logic [BYTE_W-1:0] rx_byte;
    logic              tx_req;
    logic              tx_ack;
    logic [BYTE_W-1:0] tx_byte;

    // Host side of the memory
    logic                  host_en;
    logic                  host_we;
    logic [WORD_IDX_W-1:0] host_idx;
    logic [DATA_W-1:0]     host_wdata;
    logic [DATA_W-1:0]     host_rdata;

    uart_rx u_uart_rx (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .byte_o     (rx_byte),
        .byte_req_o (rx_req),
        .byte_ack_i (rx_ack)
    );

    command_engine u_command_engine (
        .sys_clk     (sys_clk),
        .rst_n_i     (rst_n_i),
        .rx_byte_i   (rx_byte),
        .rx_req_i    (rx_req),
        .rx_ack_o    (rx_ack),
        .tx_byte_o   (tx_byte),
        .tx_req_o    (tx_req),
        .tx_ack_i    (tx_ack),
        .mem_en_o    (host_en),
        .mem_we_o    (host_we),
        .mem_idx_o   (host_idx),
        .mem_wdata_o (host_wdata),
        .mem_rdata_i (host_rdata),
        .rst_core_o  (rst_core_o)
    );

    core_memory u_core_memory (
        .sys_clk      (sys_clk),
        .rst_n_i      (rst_n_i),
        .host_en_i    (host_en),
        .host_we_i    (host_we),
        .host_idx_i   (host_idx),
        .host_wdata_i (host_wdata),
        .host_rdata_o (host_rdata),
        .core_cyc_i   (core_cyc_i),
        .core_stb_i   (core_stb_i),
        .core_we_i    (core_we_i),
        .core_wstrb_i (core_wstrb_i),
        .core_addr_i  (core_addr_i),
        .core_data_i  (core_data_i),
        .core_data_o  (core_data_o),
        .core_ack_o   (core_ack_o)
    );

    uart_tx u_uart_tx (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .byte_i     (tx_byte),
        .byte_req_i (tx_req),
        .byte_ack_o (tx_ack),
        .tx_o       (tx_o)
    );

endmodule

`default_nettype wire

// ==== test/processorci_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module processorci_controller_tb;
    import link_pkg::*;
    import bus_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int DRIVE_DLY    = 1;   // Inputs change this long after the rising edge
    localparam int BIT_NS       = CLKS_PER_BIT * CLK_PERIOD;
    localparam int SEED         = 32'h12d0_1c4b;
    localparam int N_WR         = 40;
    localparam int N_RAND_RD    = 20;
    localparam int N_CORE_WR    = 30;
    localparam int N_CORE_RD    = 20;
    localparam int ACK_WAIT_MAX = 8;

    // W is 9 bytes out and 1 back while R is 5 out and 4 back
    localparam int PLANNED_BYTES = N_WR * 10 + (N_WR + N_RAND_RD) * 9 + 2 * 2
                                 + N_CORE_WR * (10 + 9) + N_CORE_RD * 10 + 2 + 10 + 9;
    localparam int BUS_XFERS     = N_CORE_WR + N_CORE_RD;
    localparam int WATCHDOG_NS   = PLANNED_BYTES * 12 * BIT_NS + BUS_XFERS * 4 * CLK_PERIOD
                                 + 100 * BIT_NS;

    logic              sys_clk;
    logic              rst_n_i;
    logic              rx_i;
    logic              tx_o;
    logic              rst_core_o;
    logic              core_cyc_i;
    logic              core_stb_i;
    logic              core_we_i;
    logic [STRB_W-1:0] core_wstrb_i;
    logic [ADDR_W-1:0] core_addr_i;
    logic [DATA_W-1:0] core_data_i;
    logic [DATA_W-1:0] core_data_o;
    logic              core_ack_o;

    // Reference model
    logic [DATA_W-1:0] model_mem [int];
    logic              exp_rst_core;
    logic [BYTE_W-1:0] cmd_q [$];    // Bytes of the next host command
    logic [BYTE_W-1:0] reply_q [$];  // Bytes sent back by the DUT

    processorci_controller i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s expected %h, actual %h",
                                $time, name, expected, actual));
        end
    endtask

    // Bits above the word index wrap onto the same word
    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[IDX_LSB +: WORD_IDX_W]);
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    task automatic send_byte(input logic [BYTE_W-1:0] data);
        logic [BYTE_W+1:0] frame;
        frame = {1'b1, data, 1'b0};  // Start bit goes out first
        @(posedge sys_clk);
        #DRIVE_DLY;
        for (int i = 0; i < BYTE_W + 2; i++) begin
            rx_i = frame[i];
            repeat (CLKS_PER_BIT) @(posedge sys_clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic recv_byte(output logic [BYTE_W-1:0] data);
        @(negedge tx_o);
        #(BIT_NS / 2 + CLK_PERIOD / 2);  // Middle of the start bit between clock edges
        check_value("tx_o start bit", 0, tx_o);
        for (int i = 0; i < BYTE_W; i++) begin
            #(BIT_NS);
            data[i] = tx_o;
        end
        #(BIT_NS);
        check_value("tx_o stop bit", 1, tx_o);
    endtask

    // Sends cmd_q while collecting the reply bytes
    task automatic host_command(input int n_reply);
        logic [BYTE_W-1:0] rx_data;
        reply_q.delete();
        fork
            begin
                while (cmd_q.size() > 0) begin
                    send_byte(cmd_q.pop_front());
                end
            end
            begin
                repeat (n_reply) begin
                    recv_byte(rx_data);
                    reply_q.push_back(rx_data);
                end
            end
        join
    endtask

    task automatic push_word(input logic [DATA_W-1:0] word);
        for (int i = 3; i >= 0; i--) begin
            cmd_q.push_back(word[i*8 +: 8]);  // MSB first
        end
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        cmd_q.push_back(CMD_WRITE);
        push_word(addr);
        push_word(data);
        host_command(1);
        check_value("reply to W", RSP_OK, reply_q[0]);
        model_mem[word_index(addr)] = data;
    endtask

    task automatic host_read_check(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        cmd_q.push_back(CMD_READ);
        push_word(addr);
        host_command(4);
        word = {reply_q[0], reply_q[1], reply_q[2], reply_q[3]};
        // Unwritten words hold no known value
        if (model_mem.exists(word_index(addr))) begin
            check_value("R reply word", model_mem[word_index(addr)], word);
        end
    endtask

    task automatic host_single(input logic [BYTE_W-1:0] cmd, input logic [BYTE_W-1:0] expected);
        cmd_q.push_back(cmd);
        host_command(1);
        check_value("single byte reply", expected, reply_q[0]);
    endtask

    task automatic bus_transfer(input logic we, input logic [STRB_W-1:0] strb,
                                input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata);
        int waits;
        waits = 0;
        @(posedge sys_clk);
        #DRIVE_DLY;
        core_cyc_i   = 1'b1;
        core_stb_i   = 1'b1;
        core_we_i    = we;
        core_wstrb_i = strb;
        core_addr_i  = addr;
        core_data_i  = wdata;
        while (!core_ack_o && waits < ACK_WAIT_MAX) begin
            @(posedge sys_clk);
            #DRIVE_DLY;
            waits++;
        end
        if (!core_ack_o) begin
            abort_run("The core bus transfer got no ack");
        end
        check_value("core_ack_o latency", 1, waits);
        rdata = core_data_o;
        // Request stays up over the edge after the ack
        @(posedge sys_clk);
        #DRIVE_DLY;
        check_value("core_ack_o after pulse", 0, core_ack_o);
        core_cyc_i = 1'b0;
        core_stb_i = 1'b0;
        core_we_i  = 1'b0;
    endtask

    initial begin : main_seq
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rdata;
        logic [STRB_W-1:0] strb;
        logic [BYTE_W-1:0] bad_cmd;
        logic [ADDR_W-1:0] addr_q [$];
        int                idx;

        rst_n_i      = 1'b0;
        rx_i         = 1'b1;
        core_cyc_i   = 1'b0;
        core_stb_i   = 1'b0;
        core_we_i    = 1'b0;
        core_wstrb_i = '0;
        core_addr_i  = '0;
        core_data_i  = '0;
        exp_rst_core = 1'b1;
        data = $urandom(SEED);  // Seeds the generator once
        repeat (8) @(posedge sys_clk);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        @(posedge sys_clk);
        #DRIVE_DLY;
        check_value("rst_core_o", exp_rst_core, rst_core_o);
        check_value("tx_o", 1, tx_o);
        check_value("core_ack_o", 0, core_ack_o);

        repeat (N_WR) begin
            addr = $urandom();
            addr_q.push_back(addr);
            host_write(addr, $urandom());
        end
        foreach (addr_q[i]) begin
            host_read_check(addr_q[i]);
        end
        repeat (N_RAND_RD) begin
            host_read_check($urandom());
        end

        host_single(CMD_GO, RSP_OK);
        exp_rst_core = 1'b0;
        check_value("rst_core_o", exp_rst_core, rst_core_o);
        host_single(CMD_HOLD, RSP_OK);
        exp_rst_core = 1'b1;
        check_value("rst_core_o", exp_rst_core, rst_core_o);

        // Byte lane writes from the core with upper address bits set
        addr_q.delete();
        repeat (N_CORE_WR) begin
            addr = $urandom();
            data = $urandom();
            strb = $urandom();
            idx  = word_index(addr);
            if (!model_mem.exists(idx)) begin
                host_write(addr, $urandom());  // Every lane known before merging
            end
            bus_transfer(1'b1, strb, addr, data, rdata);
            model_mem[idx] = merge_lanes(model_mem[idx], data, strb);
            addr_q.push_back(addr);
        end
        foreach (addr_q[i]) begin
            host_read_check(addr_q[i]);
        end

        repeat (N_CORE_RD) begin
            addr = $urandom();
            host_write(addr, $urandom());
            data = $urandom();
            addr = {data[ADDR_W-1:12], addr[11:0]};  // Same word with other upper bits
            bus_transfer(1'b0, '0, addr, '0, rdata);
            check_value("core_data_o", model_mem[word_index(addr)], rdata);
        end

        do begin
            bad_cmd = $urandom();
        end while (bad_cmd == CMD_WRITE || bad_cmd == CMD_READ ||
                   bad_cmd == CMD_HOLD || bad_cmd == CMD_GO);
        host_single(bad_cmd, RSP_ERR);
        addr = $urandom();
        host_write(addr, $urandom());
        host_read_check(addr);

        $display("Simulation passed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("Timeout: the run did not finish in the allowed time");
    end

endmodule

`default_nettype wire

// ==== processorci_controller.f ====
common/link_pkg.sv
common/bus_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/command_engine.sv
design/core_memory.sv
design/processorci_controller.sv
test/processorci_controller_tb.sv
